//--- hw/board_io_regs.sv
// Board register block; answers port-1 requests with the DIP value and holds the port-2 LEDs
`default_nettype none

module board_io_regs
(
	input  logic              clk_local,
	input  logic              rst_local,
	input  stream_pkg::byte_t dip,
	output stream_pkg::byte_t leds,
	// DIP request, port 1
	input  logic              req_eof,
	input  logic              req_valid,
	output logic              req_ready,
	// LED write, port 2
	input  stream_pkg::byte_t led_data,
	input  logic              led_valid,
	output logic              led_ready,
	// DIP reply
	output stream_pkg::byte_t rd_data,
	output logic              rd_sof,
	output logic              rd_eof,
	output logic              rd_valid,
	input  logic              rd_ready
);
	import stream_pkg::*;

	byte_t dip_q;
	byte_t reply_q;
	logic  pending;

	// ----------------------------------------------------------
	// DIP read
	// ----------------------------------------------------------

	// One register stage on the switches
	always_ff @(posedge clk_local)
	begin
		dip_q <= dip;
		if (req_valid && req_ready && req_eof)
			reply_q <= dip_q;
	end

	// Reply pending from request end until accepted
	always_ff @(posedge clk_local)
	begin
		if (rst_local)
			pending <= 1'b0;
		else if (req_valid && req_ready && req_eof)
			pending <= 1'b1;
		else if (rd_valid && rd_ready)
			pending <= 1'b0;
	end

	// Requests stall while a reply is outstanding
	assign req_ready = !pending;

	// Single-beat reply
	assign rd_valid = pending;
	assign rd_sof   = 1'b1;
	assign rd_eof   = 1'b1;
	assign rd_data  = reply_q;

	// ----------------------------------------------------------
	// LED register
	// ----------------------------------------------------------

	assign led_ready = 1'b1;

	always_ff @(posedge clk_local)
	begin
		if (rst_local)
			leds <= '0;
		else if (led_valid)
			leds <= led_data;
	end

	a_reply_hold: assert property (@(posedge clk_local) disable iff (rst_local)
		(rd_valid && !rd_ready) |=> (rd_valid && $stable(rd_data)));

endmodule

`default_nettype wire

//--- hw/chan_config.svh
// Buffer depth and channel port numbers; include in any RTL or testbench file that needs them
`ifndef CHAN_CONFIG_SVH
`define CHAN_CONFIG_SVH

// ----------------------------------------------------------
// Frame buffer
// ----------------------------------------------------------

// Bytes held by the frame buffer, longer frames are cut here
`define BUF_DEPTH 64

// ----------------------------------------------------------
// Port numbers carried on rx_port and tx_port
// ----------------------------------------------------------

`define PORT_DIP    4'd1
`define PORT_LED    4'd2
`define PORT_BUF_WR 4'd3
`define PORT_BUF_RD 4'd4

`endif

//--- hw/chan_pkg.sv
// Channel identifiers and FSM state types for the router and frame buffer; compile before them
`default_nettype none

package chan_pkg;

	// Channel selected by a port number, CH_NONE for unused ports
	typedef enum logic [2:0] {
		CH_NONE,
		CH_DIP,
		CH_LED,
		CH_BUF_WR,
		CH_BUF_RD
	} chan_id_t;

	// Router ingress side
	typedef enum logic [1:0] {
		IDLE,
		FORWARD,
		DROP
	} route_state_t;

	// Frame buffer, HOLD is the idle state with contents kept
	typedef enum logic [1:0] {
		FILL,
		HOLD,
		REPLAY
	} buf_state_t;

endpackage

`default_nettype wire

//--- hw/chan_top.sv
// Channel subsystem top; connects the router to the board registers and the frame buffer
`default_nettype none

module chan_top
(
	input  logic              clk_local,
	input  logic              rst_local,
	input  stream_pkg::byte_t rx_data,
	input  logic              rx_sof,
	input  logic              rx_eof,
	input  logic              rx_src_rdy,
	input  stream_pkg::port_t rx_port,
	output logic              rx_dst_rdy,
	output stream_pkg::byte_t tx_data,
	output logic              tx_sof,
	output logic              tx_eof,
	output logic              tx_src_rdy,
	output stream_pkg::port_t tx_port,
	input  logic              tx_dst_rdy,
	input  stream_pkg::byte_t dip,
	output stream_pkg::byte_t leds
);
	import stream_pkg::*;

	// ----------------------------------------------------------
	// Channel wires
	// ----------------------------------------------------------

	// DIP request and reply
	logic  c1_wr_eof;
	logic  c1_wr_valid;
	logic  c1_wr_ready;
	byte_t c1_rd_data;
	logic  c1_rd_sof;
	logic  c1_rd_eof;
	logic  c1_rd_valid;
	logic  c1_rd_ready;
	// LED write
	byte_t c2_wr_data;
	logic  c2_wr_valid;
	logic  c2_wr_ready;
	// Buffer write
	byte_t c3_wr_data;
	logic  c3_wr_sof;
	logic  c3_wr_eof;
	logic  c3_wr_valid;
	logic  c3_wr_ready;
	// Buffer request and reply
	logic  c4_wr_sof;
	logic  c4_wr_eof;
	logic  c4_wr_valid;
	logic  c4_wr_ready;
	byte_t c4_rd_data;
	logic  c4_rd_sof;
	logic  c4_rd_eof;
	logic  c4_rd_valid;
	logic  c4_rd_ready;

	// ----------------------------------------------------------
	// Instances
	// ----------------------------------------------------------

	// Request payload on ports 1 and 4 and LED framing are not needed downstream
	channel_router router_inst
	(
		.clk_local   (clk_local),
		.rst_local   (rst_local),
		.rx_data     (rx_data),
		.rx_sof      (rx_sof),
		.rx_eof      (rx_eof),
		.rx_src_rdy  (rx_src_rdy),
		.rx_port     (rx_port),
		.rx_dst_rdy  (rx_dst_rdy),
		.tx_data     (tx_data),
		.tx_sof      (tx_sof),
		.tx_eof      (tx_eof),
		.tx_src_rdy  (tx_src_rdy),
		.tx_port     (tx_port),
		.tx_dst_rdy  (tx_dst_rdy),
		.c1_wr_data  (),
		.c1_wr_sof   (),
		.c1_wr_eof   (c1_wr_eof),
		.c1_wr_valid (c1_wr_valid),
		.c1_wr_ready (c1_wr_ready),
		.c2_wr_data  (c2_wr_data),
		.c2_wr_sof   (),
		.c2_wr_eof   (),
		.c2_wr_valid (c2_wr_valid),
		.c2_wr_ready (c2_wr_ready),
		.c3_wr_data  (c3_wr_data),
		.c3_wr_sof   (c3_wr_sof),
		.c3_wr_eof   (c3_wr_eof),
		.c3_wr_valid (c3_wr_valid),
		.c3_wr_ready (c3_wr_ready),
		.c4_wr_data  (),
		.c4_wr_sof   (c4_wr_sof),
		.c4_wr_eof   (c4_wr_eof),
		.c4_wr_valid (c4_wr_valid),
		.c4_wr_ready (c4_wr_ready),
		.c1_rd_data  (c1_rd_data),
		.c1_rd_sof   (c1_rd_sof),
		.c1_rd_eof   (c1_rd_eof),
		.c1_rd_valid (c1_rd_valid),
		.c1_rd_ready (c1_rd_ready),
		.c4_rd_data  (c4_rd_data),
		.c4_rd_sof   (c4_rd_sof),
		.c4_rd_eof   (c4_rd_eof),
		.c4_rd_valid (c4_rd_valid),
		.c4_rd_ready (c4_rd_ready)
	);

	board_io_regs regs_inst
	(
		.clk_local (clk_local),
		.rst_local (rst_local),
		.dip       (dip),
		.leds      (leds),
		.req_eof   (c1_wr_eof),
		.req_valid (c1_wr_valid),
		.req_ready (c1_wr_ready),
		.led_data  (c2_wr_data),
		.led_valid (c2_wr_valid),
		.led_ready (c2_wr_ready),
		.rd_data   (c1_rd_data),
		.rd_sof    (c1_rd_sof),
		.rd_eof    (c1_rd_eof),
		.rd_valid  (c1_rd_valid),
		.rd_ready  (c1_rd_ready)
	);

	frame_buffer buffer_inst
	(
		.clk_local (clk_local),
		.rst_local (rst_local),
		.wr_data   (c3_wr_data),
		.wr_sof    (c3_wr_sof),
		.wr_eof    (c3_wr_eof),
		.wr_valid  (c3_wr_valid),
		.wr_ready  (c3_wr_ready),
		.req_sof   (c4_wr_sof),
		.req_eof   (c4_wr_eof),
		.req_valid (c4_wr_valid),
		.req_ready (c4_wr_ready),
		.rd_data   (c4_rd_data),
		.rd_sof    (c4_rd_sof),
		.rd_eof    (c4_rd_eof),
		.rd_valid  (c4_rd_valid),
		.rd_ready  (c4_rd_ready)
	);

endmodule

`default_nettype wire

//--- hw/channel_router.sv
// Host stream router; splits rx frames to four channels by port and merges replies onto tx
`default_nettype none

`include "chan_config.svh"

module channel_router
(
	input  logic              clk_local,
	input  logic              rst_local,
	// Host to device
	input  stream_pkg::byte_t rx_data,
	input  logic              rx_sof,
	input  logic              rx_eof,
	input  logic              rx_src_rdy,
	input  stream_pkg::port_t rx_port,
	output logic              rx_dst_rdy,
	// Device to host
	output stream_pkg::byte_t tx_data,
	output logic              tx_sof,
	output logic              tx_eof,
	output logic              tx_src_rdy,
	output stream_pkg::port_t tx_port,
	input  logic              tx_dst_rdy,
	// Channel write paths
	output stream_pkg::byte_t c1_wr_data,
	output logic              c1_wr_sof,
	output logic              c1_wr_eof,
	output logic              c1_wr_valid,
	input  logic              c1_wr_ready,
	output stream_pkg::byte_t c2_wr_data,
	output logic              c2_wr_sof,
	output logic              c2_wr_eof,
	output logic              c2_wr_valid,
	input  logic              c2_wr_ready,
	output stream_pkg::byte_t c3_wr_data,
	output logic              c3_wr_sof,
	output logic              c3_wr_eof,
	output logic              c3_wr_valid,
	input  logic              c3_wr_ready,
	output stream_pkg::byte_t c4_wr_data,
	output logic              c4_wr_sof,
	output logic              c4_wr_eof,
	output logic              c4_wr_valid,
	input  logic              c4_wr_ready,
	// Reply paths
	input  stream_pkg::byte_t c1_rd_data,
	input  logic              c1_rd_sof,
	input  logic              c1_rd_eof,
	input  logic              c1_rd_valid,
	output logic              c1_rd_ready,
	input  stream_pkg::byte_t c4_rd_data,
	input  logic              c4_rd_sof,
	input  logic              c4_rd_eof,
	input  logic              c4_rd_valid,
	output logic              c4_rd_ready
);
	import stream_pkg::*;
	import chan_pkg::*;

	route_state_t route_state;
	chan_id_t     route_ch;
	chan_id_t     sof_ch;
	chan_id_t     cur_ch;
	logic         rx_fire;
	chan_id_t     egr_grant;
	chan_id_t     egr_sel;
	logic         tx_fire;

	// Port number to channel
	function automatic chan_id_t port_to_chan(input port_t port);
		chan_id_t ch;
		case (port)
			`PORT_DIP:    ch = CH_DIP;
			`PORT_LED:    ch = CH_LED;
			`PORT_BUF_WR: ch = CH_BUF_WR;
			`PORT_BUF_RD: ch = CH_BUF_RD;
			default:      ch = CH_NONE;
		endcase
		return ch;
	endfunction

	// ----------------------------------------------------------
	// Ingress
	// ----------------------------------------------------------

	assign sof_ch = port_to_chan(rx_port);

	// First beat steers from rx_port directly, later beats from the latch
	always_comb
	begin
		case (route_state)
			IDLE:    cur_ch = rx_sof ? sof_ch : CH_NONE;
			FORWARD: cur_ch = route_ch;
			default: cur_ch = CH_NONE;
		endcase
	end

	// Unused ports and stray beats are swallowed
	always_comb
	begin
		case (cur_ch)
			CH_DIP:    rx_dst_rdy = c1_wr_ready;
			CH_LED:    rx_dst_rdy = c2_wr_ready;
			CH_BUF_WR: rx_dst_rdy = c3_wr_ready;
			CH_BUF_RD: rx_dst_rdy = c4_wr_ready;
			default:   rx_dst_rdy = 1'b1;
		endcase
	end

	assign rx_fire = rx_src_rdy && rx_dst_rdy;

	always_ff @(posedge clk_local)
	begin
		if (rst_local)
		begin
			route_state <= IDLE;
			route_ch    <= CH_NONE;
		end
		else if (rx_fire)
		begin
			case (route_state)
				IDLE:
				begin
					// Single-beat frames never leave IDLE
					if (rx_sof && !rx_eof)
					begin
						route_state <= (sof_ch == CH_NONE) ? DROP : FORWARD;
						route_ch    <= sof_ch;
					end
				end
				default:
				begin
					if (rx_eof)
						route_state <= IDLE;
				end
			endcase
		end
	end

	// Broadcast payload, only the valid is steered
	assign c1_wr_data  = rx_data;
	assign c1_wr_sof   = rx_sof;
	assign c1_wr_eof   = rx_eof;
	assign c1_wr_valid = rx_src_rdy && (cur_ch == CH_DIP);
	assign c2_wr_data  = rx_data;
	assign c2_wr_sof   = rx_sof;
	assign c2_wr_eof   = rx_eof;
	assign c2_wr_valid = rx_src_rdy && (cur_ch == CH_LED);
	assign c3_wr_data  = rx_data;
	assign c3_wr_sof   = rx_sof;
	assign c3_wr_eof   = rx_eof;
	assign c3_wr_valid = rx_src_rdy && (cur_ch == CH_BUF_WR);
	assign c4_wr_data  = rx_data;
	assign c4_wr_sof   = rx_sof;
	assign c4_wr_eof   = rx_eof;
	assign c4_wr_valid = rx_src_rdy && (cur_ch == CH_BUF_RD);

	// ----------------------------------------------------------
	// Egress
	// ----------------------------------------------------------

	// Locked grant first, else a new frame start, DIP ahead of buffer
	always_comb
	begin
		if (egr_grant != CH_NONE)
			egr_sel = egr_grant;
		else if (c1_rd_valid && c1_rd_sof)
			egr_sel = CH_DIP;
		else if (c4_rd_valid && c4_rd_sof)
			egr_sel = CH_BUF_RD;
		else
			egr_sel = CH_NONE;
	end

	always_comb
	begin
		tx_data    = '0;
		tx_sof     = 1'b0;
		tx_eof     = 1'b0;
		tx_src_rdy = 1'b0;
		tx_port    = '0;
		case (egr_sel)
			CH_DIP:
			begin
				tx_data    = c1_rd_data;
				tx_sof     = c1_rd_sof;
				tx_eof     = c1_rd_eof;
				tx_src_rdy = c1_rd_valid;
				tx_port    = `PORT_DIP;
			end
			CH_BUF_RD:
			begin
				tx_data    = c4_rd_data;
				tx_sof     = c4_rd_sof;
				tx_eof     = c4_rd_eof;
				tx_src_rdy = c4_rd_valid;
				tx_port    = `PORT_BUF_RD;
			end
			default:
			begin
			end
		endcase
	end

	assign tx_fire     = tx_src_rdy && tx_dst_rdy;
	assign c1_rd_ready = tx_dst_rdy && (egr_sel == CH_DIP);
	assign c4_rd_ready = tx_dst_rdy && (egr_sel == CH_BUF_RD);

	// Lock on the first presented beat so a stalled frame start cannot be preempted
	always_ff @(posedge clk_local)
	begin
		if (rst_local)
			egr_grant <= CH_NONE;
		else if (tx_fire && tx_eof)
			egr_grant <= CH_NONE;
		else
			egr_grant <= egr_sel;
	end

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------

	a_wr_onehot: assert property (@(posedge clk_local) disable iff (rst_local)
		$onehot0({c1_wr_valid, c2_wr_valid, c3_wr_valid, c4_wr_valid}));

	// Reply beat held while host stalls, relies on the channel sources holding too
	a_tx_hold: assert property (@(posedge clk_local) disable iff (rst_local)
		(tx_src_rdy && !tx_dst_rdy) |=> (tx_src_rdy && $stable(tx_data) && $stable(tx_sof)
			&& $stable(tx_eof) && $stable(tx_port)));

endmodule

`default_nettype wire

//--- hw/frame_buffer.sv
// One-frame byte buffer; port 3 writes a frame, a port-4 request replays it as a reply
`default_nettype none

`include "chan_config.svh"

module frame_buffer
(
	input  logic              clk_local,
	input  logic              rst_local,
	// Write path, port 3
	input  stream_pkg::byte_t wr_data,
	input  logic              wr_sof,
	input  logic              wr_eof,
	input  logic              wr_valid,
	output logic              wr_ready,
	// Request path, port 4
	input  logic              req_sof,
	input  logic              req_eof,
	input  logic              req_valid,
	output logic              req_ready,
	// Reply path
	output stream_pkg::byte_t rd_data,
	output logic              rd_sof,
	output logic              rd_eof,
	output logic              rd_valid,
	input  logic              rd_ready
);
	import stream_pkg::*;
	import chan_pkg::*;

	localparam int ADDR_W = $clog2(`BUF_DEPTH);
	localparam int CNT_W  = $clog2(`BUF_DEPTH + 1);

	byte_t             mem [`BUF_DEPTH];
	buf_state_t        buf_state;
	logic [CNT_W-1:0]  fill_cnt;
	logic [ADDR_W-1:0] rd_ptr;
	logic [ADDR_W-1:0] wr_addr;
	logic              wr_fire;
	logic              wr_store;
	logic              req_fire;
	logic              rd_fire;
	logic              below_depth;
	logic              buf_empty;

	// ----------------------------------------------------------
	// Write side
	// ----------------------------------------------------------

	// Both inputs blocked while replaying
	assign wr_ready  = (buf_state != REPLAY);
	assign req_ready = (buf_state != REPLAY);
	assign wr_fire   = wr_valid && wr_ready;
	assign req_fire  = req_valid && req_ready;

	assign below_depth = (fill_cnt < CNT_W'(`BUF_DEPTH));
	assign buf_empty   = (fill_cnt == '0);

	// New sof always lands at zero; later beats only inside a frame and below depth
	assign wr_store = wr_fire && (wr_sof || ((buf_state == FILL) && below_depth));
	assign wr_addr  = wr_sof ? '0 : fill_cnt[ADDR_W-1:0];

	always_ff @(posedge clk_local)
	begin
		if (wr_store)
			mem[wr_addr] <= wr_data;
	end

	// ----------------------------------------------------------
	// Read side
	// ----------------------------------------------------------

	// Empty buffer answers with a single zero byte
	assign rd_valid = (buf_state == REPLAY);
	assign rd_data  = buf_empty ? '0 : mem[rd_ptr];
	assign rd_sof   = (rd_ptr == '0);
	assign rd_eof   = buf_empty || ((CNT_W'(rd_ptr) + CNT_W'(1)) == fill_cnt);
	assign rd_fire  = rd_valid && rd_ready;

	// ----------------------------------------------------------
	// Control
	// ----------------------------------------------------------

	always_ff @(posedge clk_local)
	begin
		if (rst_local)
		begin
			buf_state <= HOLD;
			fill_cnt  <= '0;
			rd_ptr    <= '0;
		end
		else
		begin
			case (buf_state)
				REPLAY:
				begin
					if (rd_fire && rd_eof)
					begin
						buf_state <= HOLD;
						rd_ptr    <= '0;
					end
					else if (rd_fire)
						rd_ptr <= rd_ptr + 1'b1;
				end
				default:
				begin
					// Request end starts replay next cycle
					if (req_fire && req_eof)
						buf_state <= REPLAY;
					else if (wr_fire && wr_eof)
						buf_state <= HOLD;
					else if (wr_fire && wr_sof)
						buf_state <= FILL;
				end
			endcase
			// Count restarts on sof
			if (wr_store)
				fill_cnt <= wr_sof ? CNT_W'(1) : fill_cnt + 1'b1;
		end
	end

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------

	a_cnt_bound: assert property (@(posedge clk_local) disable iff (rst_local)
		fill_cnt <= CNT_W'(`BUF_DEPTH));

	// Router never starts a request inside an open write frame
	a_no_overlap: assert property (@(posedge clk_local) disable iff (rst_local)
		(req_valid && req_sof) |-> (buf_state != FILL));

endmodule

`default_nettype wire

//--- hw/stream_pkg.sv
// Beat and port-address types for every byte stream; compile before the RTL that uses them
`default_nettype none

package stream_pkg;

	// ----------------------------------------------------------
	// Stream payload
	// ----------------------------------------------------------

	// One data beat on any rx, tx or channel stream
	typedef logic [7:0] byte_t;

	// ----------------------------------------------------------
	// Addressing
	// ----------------------------------------------------------

	// Port address, constant for the whole frame
	typedef logic [3:0] port_t;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing -Wno-fatal -f tb.f --top-module chan_tb -o chan_sim >&2 \
	&& ./obj_dir/chan_sim)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx 'Done: no errors' \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }

//--- tb.f
+incdir+hw
hw/stream_pkg.sv
hw/chan_pkg.sv
hw/channel_router.sv
hw/frame_buffer.sv
hw/board_io_regs.sv
hw/chan_top.sv
verif/chan_tb.sv

//--- verif/chan_tb.sv
// Random-stimulus testbench for chan_top; compile with tb.f and run chan_tb as the top module
`default_nettype none

`include "chan_config.svh"

module chan_tb;
	import stream_pkg::*;

	localparam int TIMEOUT = 2000;

	logic  clk_local;
	logic  rst_local;
	byte_t rx_data;
	logic  rx_sof;
	logic  rx_eof;
	logic  rx_src_rdy;
	port_t rx_port;
	logic  rx_dst_rdy;
	byte_t tx_data;
	logic  tx_sof;
	logic  tx_eof;
	logic  tx_src_rdy;
	port_t tx_port;
	logic  tx_dst_rdy;
	byte_t dip;
	byte_t leds;

	// Expected reply beats, one entry per beat in tx order
	byte_t exp_data [$];
	logic  exp_sof [$];
	logic  exp_eof [$];
	port_t exp_port [$];
	// Model of buffer contents and LED register
	byte_t buf_model [$];
	byte_t led_model;
	// Frame payload being sent
	byte_t payload [$];
	int    seed;
	int    error_count;
	int    check_count;

	chan_top chan_top_inst
	(
		.clk_local  (clk_local),
		.rst_local  (rst_local),
		.rx_data    (rx_data),
		.rx_sof     (rx_sof),
		.rx_eof     (rx_eof),
		.rx_src_rdy (rx_src_rdy),
		.rx_port    (rx_port),
		.rx_dst_rdy (rx_dst_rdy),
		.tx_data    (tx_data),
		.tx_sof     (tx_sof),
		.tx_eof     (tx_eof),
		.tx_src_rdy (tx_src_rdy),
		.tx_port    (tx_port),
		.tx_dst_rdy (tx_dst_rdy),
		.dip        (dip),
		.leds       (leds)
	);

	always #50 clk_local = ~clk_local;

	// Host stalls about a quarter of the time
	always @(posedge clk_local)
	begin
		#1;
		tx_dst_rdy = (($random(seed) & 3) != 0);
	end

	// ----------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		check_count++;
		if (actual !== expected)
		begin
			$display("** Error at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
			error_count++;
		end
	endtask

	task automatic abort_run(input string why);
		error_count++;
		$display("Timeout at %0t: %s within %0d cycles", $time, why, TIMEOUT);
		$display("Done: errors found");
		$finish;
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("Test %s finished with %0d errors", name, error_count - errs_before);
	endtask

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed) & 32'h7fffffff;
		return lo + (r % (hi - lo + 1));
	endfunction

	task automatic fill_payload(input int len);
		payload.delete();
		repeat (len)
			payload.push_back(byte_t'($random(seed)));
	endtask

	// New switch value, held two edges so the sample register settles
	task automatic set_dip(input byte_t value);
		dip = value;
		repeat (2) @(posedge clk_local);
		#1;
	endtask

	task automatic push_reply(input byte_t data, input logic sof, input logic eof,
		input port_t port);
		exp_data.push_back(data);
		exp_sof.push_back(sof);
		exp_eof.push_back(eof);
		exp_port.push_back(port);
	endtask

	// One rx beat, held until accepted
	task automatic send_beat(input byte_t data, input logic sof, input logic eof,
		input port_t port);
		int cnt;
		rx_data    = data;
		rx_sof     = sof;
		rx_eof     = eof;
		rx_port    = port;
		rx_src_rdy = 1'b1;
		cnt = 0;
		@(negedge clk_local);
		while (!rx_dst_rdy && cnt < TIMEOUT)
		begin
			@(negedge clk_local);
			cnt++;
		end
		if (!rx_dst_rdy)
			abort_run("rx beat was never accepted");
		else
		begin
			@(posedge clk_local);
			#1;
			rx_src_rdy = 1'b0;
		end
	endtask

	// Model update first, then the payload goes out on rx
	task automatic send_frame(input port_t port);
		int n;
		int i;
		n = payload.size();
		case (port)
			`PORT_DIP:
				push_reply(dip, 1'b1, 1'b1, `PORT_DIP);
			`PORT_BUF_WR:
			begin
				buf_model.delete();
				for (i = 0; i < n && i < `BUF_DEPTH; i++)
					buf_model.push_back(payload[i]);
			end
			`PORT_BUF_RD:
			begin
				// Empty buffer answers with one zero byte
				if (buf_model.size() == 0)
					push_reply(8'h00, 1'b1, 1'b1, `PORT_BUF_RD);
				else
					for (i = 0; i < buf_model.size(); i++)
						push_reply(buf_model[i], i == 0, i == buf_model.size() - 1, `PORT_BUF_RD);
			end
			default:
			begin
			end
		endcase
		for (i = 0; i < n; i++)
			send_beat(payload[i], i == 0, i == n - 1, port);
		if (port == `PORT_LED)
		begin
			led_model = payload[n - 1];
			check_value(leds, led_model, "leds");
		end
	endtask

	// Waits until every expected beat is seen, then idles to catch stray beats
	task automatic wait_drain();
		int cnt;
		cnt = 0;
		@(negedge clk_local);
		while (exp_data.size() != 0 && cnt < TIMEOUT)
		begin
			@(negedge clk_local);
			cnt++;
		end
		if (exp_data.size() != 0)
			abort_run("expected reply beats did not arrive");
		else
		begin
			repeat (10) @(negedge clk_local);
			@(posedge clk_local);
			#1;
		end
	endtask

	task automatic reset_dut();
		rst_local  = 1'b1;
		rx_src_rdy = 1'b0;
		repeat (10) @(posedge clk_local);
		#1;
		rst_local = 1'b0;
		buf_model.delete();
		led_model = 8'h00;
	endtask

	// ----------------------------------------------------------
	// Reply monitor
	// ----------------------------------------------------------

	// Sampled mid-cycle, where rx and tx are both settled
	always @(negedge clk_local)
	begin
		if (!rst_local && tx_src_rdy && tx_dst_rdy)
		begin
			if (exp_data.size() == 0)
			begin
				$display("Unexpected reply beat at %0t on port %0d", $time, tx_port);
				error_count++;
			end
			else
			begin
				check_value(tx_data, exp_data.pop_front(), "tx_data");
				check_value(tx_sof, exp_sof.pop_front(), "tx_sof");
				check_value(tx_eof, exp_eof.pop_front(), "tx_eof");
				check_value(tx_port, exp_port.pop_front(), "tx_port");
			end
		end
	end

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------

	initial
	begin
		int    errs;
		port_t port;
		int    len;
		seed        = 53;
		error_count = 0;
		check_count = 0;
		clk_local   = 1'b0;
		rst_local   = 1'b1;
		rx_data     = 8'h00;
		rx_sof      = 1'b0;
		rx_eof      = 1'b0;
		rx_src_rdy  = 1'b0;
		rx_port     = 4'd0;
		tx_dst_rdy  = 1'b0;
		dip         = 8'h00;
		led_model   = 8'h00;
		reset_dut();

		// Idle after reset
		errs = error_count;
		check_value(leds, 8'h00, "leds after reset");
		repeat (20)
		begin
			@(negedge clk_local);
			check_value(tx_src_rdy, 1'b0, "tx_src_rdy while idle");
		end
		@(posedge clk_local);
		#1;
		report_test("reset", errs);

		// DIP requests of random length
		errs = error_count;
		repeat (8)
		begin
			set_dip(byte_t'($random(seed)));
			fill_payload(rand_range(1, 4));
			send_frame(`PORT_DIP);
		end
		wait_drain();
		report_test("dip read", errs);

		// LED frames, no reply expected
		errs = error_count;
		repeat (8)
		begin
			fill_payload(rand_range(1, 6));
			send_frame(`PORT_LED);
		end
		wait_drain();
		report_test("led write", errs);

		// Empty buffer after reset, then round trips past the depth
		errs = error_count;
		reset_dut();
		fill_payload(rand_range(1, 3));
		send_frame(`PORT_BUF_RD);
		wait_drain();
		repeat (4)
		begin
			fill_payload(rand_range(1, 80));
			send_frame(`PORT_BUF_WR);
			fill_payload(rand_range(1, 3));
			send_frame(`PORT_BUF_RD);
			wait_drain();
		end
		report_test("buffer round trip", errs);

		// Mixed ports including unused ones
		errs = error_count;
		repeat (60)
		begin
			port = port_t'(rand_range(0, 6));
			len  = (port == `PORT_BUF_WR) ? rand_range(1, 80) : rand_range(1, 6);
			if (rand_range(0, 7) == 0)
				set_dip(byte_t'($random(seed)));
			fill_payload(len);
			send_frame(port);
			if (rand_range(0, 3) == 0)
			begin
				@(posedge clk_local);
				#1;
			end
		end
		wait_drain();
		report_test("mixed traffic", errs);

		$display("Checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
